// File: Makefile
VERILATOR   ?= verilator
TOP         := tb_kem_ctrl
FILELIST    := filelist.f
OBJ_DIR     := obj_dir
COMMON_FLAGS := --timing --assert
BUILD_FLAGS := --binary -j 0 $(COMMON_FLAGS)
LINT_FLAGS  := --lint-only $(COMMON_FLAGS)
PASS_MSG    := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/kem_ctrl_pkg.sv
// shared encodings for the kem controller; at most 8 instructions per mode, rates in 64-bit words
`default_nettype none

package kem_ctrl_pkg;

    // instruction opcodes
    typedef enum logic [1:0] {
        OP_END  = 2'd0,
        OP_DIN  = 2'd1,
        OP_DOUT = 2'd2,
        OP_HASH = 2'd3   // absorb source, squeeze one block to destination
    } op_e;

    // sequencer states
    typedef enum logic [2:0] {
        WAIT = 3'd0,
        DIN  = 3'd1,
        DOUT = 3'd2,
        ABS  = 3'd3,
        RUN  = 3'd4,    // keccak permutation in flight
        SQZ  = 3'd5,
        DONE = 3'd6
    } seq_state_e;

    localparam int PC_W  = 3;
    localparam int LEN_W = 7;    // word count per instruction
    localparam int CNT_W = 5;    // absorb / squeeze counters

    localparam logic BANK_A = 1'b0;
    localparam logic BANK_B = 1'b1;

    // sponge rate in 64-bit words
    localparam logic [CNT_W-1:0] RATE_128 = 5'd21;
    localparam logic [CNT_W-1:0] RATE_256 = 5'd17;

endpackage

`default_nettype wire

// File: design/addr_channel.sv
// address moves on the cycle after adv; advances while full are dropped
`timescale 1ns/1ps
`default_nettype none

module addr_channel #(
    parameter int ADDR_W = 12
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            load,
    input  logic                            adv,
    input  logic [ADDR_W-1:0]               base,
    input  logic [kem_ctrl_pkg::LEN_W-1:0]  len,
    output logic [ADDR_W-1:0]               addr,
    output logic                            full
);

    logic [kem_ctrl_pkg::LEN_W-1:0] cnt;   // advances since load
    logic [kem_ctrl_pkg::LEN_W-1:0] lim;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr <= '0;
            cnt  <= '0;
            lim  <= '0;
        end else if (load) begin
            addr <= base;
            cnt  <= '0;
            lim  <= len;
        end else if (adv && !full) begin
            addr <= addr + 1'b1;
            cnt  <= cnt + 1'b1;
        end
    end

    assign full = (cnt == lim);    // idle channels read as full

endmodule

`default_nettype wire

// File: design/bank_router.sv
// lowest-numbered channel on a bank owns its address; write needs adv and the write flag
`timescale 1ns/1ps
`default_nettype none

module bank_router #(
    parameter int ADDR_W   = 12,
    parameter int NUM_CHAN = 2
) (
    input  logic [NUM_CHAN-1:0][ADDR_W-1:0]  ch_addr,
    input  logic [NUM_CHAN-1:0]              ch_adv,
    input  logic [NUM_CHAN-1:0]              ch_write,
    input  logic [NUM_CHAN-1:0]              ch_bank,
    output logic [ADDR_W-1:0]                addr_64rama,
    output logic [ADDR_W-1:0]                addr_64ramb,
    output logic                             we_64rama,
    output logic                             we_64ramb
);

    logic [NUM_CHAN-1:0] wr_a;
    logic [NUM_CHAN-1:0] wr_b;

    always_comb begin
        logic hit_a;
        logic hit_b;
        hit_a       = 1'b0;
        hit_b       = 1'b0;
        addr_64rama = '0;
        addr_64ramb = '0;
        we_64rama   = 1'b0;
        we_64ramb   = 1'b0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            wr_a[i] = ch_adv[i] && ch_write[i] && (ch_bank[i] == kem_ctrl_pkg::BANK_A);
            wr_b[i] = ch_adv[i] && ch_write[i] && (ch_bank[i] == kem_ctrl_pkg::BANK_B);
            if (!hit_a && ch_bank[i] == kem_ctrl_pkg::BANK_A) begin
                hit_a       = 1'b1;
                addr_64rama = ch_addr[i];
                we_64rama   = ch_adv[i] && ch_write[i];
            end
            if (!hit_b && ch_bank[i] == kem_ctrl_pkg::BANK_B) begin
                hit_b       = 1'b1;
                addr_64ramb = ch_addr[i];
                we_64ramb   = ch_adv[i] && ch_write[i];
            end
        end
    end

    always_comb begin
        a_one_writer: assert ($onehot0(wr_a) && $onehot0(wr_b))
            else $error("two channels writing one bank");
    end

endmodule

`default_nettype wire

// File: design/kem_ctrl_top.sv
// rom programs are fixed; all waiting is on data_ival, onehash_val and sqzout_val with no back-pressure
`timescale 1ns/1ps
`default_nettype none

module kem_ctrl_top #(
    parameter int ADDR_W   = 12,
    parameter int NUM_CHAN = 2
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic [1:0]         sec_lvl,
    input  logic [1:0]         opermode,
    input  logic               start,
    input  logic               data_ival,
    input  logic               onehash_val,
    input  logic               sqzout_val,
    output logic               work_done,
    output logic               data_oval,
    output logic               msg_val,
    output logic               lastmsg_val,
    output logic               sqzout_en,
    output logic [ADDR_W-1:0]  addr_64rama,
    output logic [ADDR_W-1:0]  addr_64ramb,
    output logic               we_64rama,
    output logic               we_64ramb
);

    kem_ctrl_pkg::op_e                            op;
    kem_ctrl_pkg::seq_state_e                     state;
    logic [kem_ctrl_pkg::PC_W-1:0]                pc;
    logic                                         src_bank, dst_bank;
    logic [ADDR_W-1:0]                            src_base, dst_base;
    logic [kem_ctrl_pkg::LEN_W-1:0]               len;
    logic                                         abs_done, sqz_done, words_left;
    logic [NUM_CHAN-1:0]                          ch_load, ch_adv, ch_write, ch_bank, ch_full;
    logic [NUM_CHAN-1:0][ADDR_W-1:0]              ch_base, ch_addr;
    logic [NUM_CHAN-1:0][kem_ctrl_pkg::LEN_W-1:0] ch_len;

    inst_rom #(.ADDR_W(ADDR_W)) u_rom (
        .clk(clk), .opermode(opermode), .pc(pc), .op(op),
        .src_bank(src_bank), .dst_bank(dst_bank),
        .src_base(src_base), .dst_base(dst_base), .len(len)
    );

    op_sequencer #(.ADDR_W(ADDR_W), .NUM_CHAN(NUM_CHAN)) u_seq (
        .clk(clk), .rstn(rstn), .start(start), .data_ival(data_ival),
        .onehash_val(onehash_val), .sqzout_val(sqzout_val), .op(op),
        .src_bank(src_bank), .dst_bank(dst_bank), .src_base(src_base), .dst_base(dst_base),
        .len(len), .abs_done(abs_done), .sqz_done(sqz_done), .words_left(words_left),
        .ch_full(ch_full), .pc(pc), .ch_load(ch_load), .ch_adv(ch_adv), .ch_write(ch_write),
        .ch_bank(ch_bank), .ch_base(ch_base), .ch_len(ch_len), .state(state),
        .data_oval(data_oval), .work_done(work_done)
    );

    sponge_tracker u_sponge (
        .clk(clk), .rstn(rstn), .sec_lvl(sec_lvl), .state(state),
        .src_adv(ch_adv[0]), .src_full(ch_full[0]),
        .sqzout_val(sqzout_val), .onehash_val(onehash_val),
        .msg_val(msg_val), .lastmsg_val(lastmsg_val), .sqzout_en(sqzout_en),
        .abs_done(abs_done), .sqz_done(sqz_done), .words_left(words_left)
    );

    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        addr_channel #(.ADDR_W(ADDR_W)) u_chan (
            .clk(clk), .rstn(rstn), .load(ch_load[i]), .adv(ch_adv[i]),
            .base(ch_base[i]), .len(ch_len[i]), .addr(ch_addr[i]), .full(ch_full[i])
        );
    end

    bank_router #(.ADDR_W(ADDR_W), .NUM_CHAN(NUM_CHAN)) u_router (
        .ch_addr(ch_addr), .ch_adv(ch_adv), .ch_write(ch_write), .ch_bank(ch_bank),
        .addr_64rama(addr_64rama), .addr_64ramb(addr_64ramb),
        .we_64rama(we_64rama), .we_64ramb(we_64ramb)
    );

endmodule

`default_nettype wire

// File: design/sponge_tracker.sv
// only sec_lvl[0] picks the rate; msg_val lags the source advance by exactly one cycle
`timescale 1ns/1ps
`default_nettype none

module sponge_tracker (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [1:0]                sec_lvl,
    input  kem_ctrl_pkg::seq_state_e  state,
    input  logic                      src_adv,
    input  logic                      src_full,
    input  logic                      sqzout_val,
    input  logic                      onehash_val,
    output logic                      msg_val,
    output logic                      lastmsg_val,
    output logic                      sqzout_en,
    output logic                      abs_done,
    output logic                      sqz_done,
    output logic                      words_left
);

    logic [kem_ctrl_pkg::CNT_W-1:0] rate;
    logic [kem_ctrl_pkg::CNT_W-1:0] abs_cnt;   // words absorbed in this block
    logic [kem_ctrl_pkg::CNT_W-1:0] sqz_cnt;

    assign rate = sec_lvl[0] ? kem_ctrl_pkg::RATE_128 : kem_ctrl_pkg::RATE_256;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            msg_val <= 1'b0;
            abs_cnt <= '0;
            sqz_cnt <= '0;
        end else begin
            msg_val <= src_adv && (state == kem_ctrl_pkg::ABS);
            if (onehash_val || state == kem_ctrl_pkg::WAIT)
                abs_cnt <= '0;    // new block
            else if (src_adv && state == kem_ctrl_pkg::ABS)
                abs_cnt <= abs_cnt + 1'b1;
            if (state != kem_ctrl_pkg::SQZ)
                sqz_cnt <= '0;
            else if (sqzout_val && sqzout_en)
                sqz_cnt <= sqz_cnt + 1'b1;
        end
    end

    // source channel goes full on the same cycle the last word is presented
    assign lastmsg_val = msg_val && src_full;
    assign sqzout_en   = (state == kem_ctrl_pkg::SQZ) && (sqz_cnt < rate);
    assign abs_done    = (abs_cnt == rate);
    assign sqz_done    = (sqz_cnt == rate);
    assign words_left  = !src_full;

    a_block_rate: assert property (@(posedge clk) disable iff (!rstn)
        msg_val |-> (abs_cnt != '0) && (abs_cnt <= rate));

endmodule

`default_nettype wire

// File: filelist.f
common/kem_ctrl_pkg.sv
sequencer/inst_rom.sv
sequencer/op_sequencer.sv
design/sponge_tracker.sv
design/addr_channel.sv
design/bank_router.sv
design/kem_ctrl_top.sv
verif/tb_kem_ctrl.sv

// File: sequencer/inst_rom.sv
// fixed programs, one per opermode; read has 1 cycle latency; mode 2 dout length assumes rate 17
`timescale 1ns/1ps
`default_nettype none

module inst_rom #(
    parameter int ADDR_W = 12
) (
    input  logic                             clk,
    input  logic [1:0]                       opermode,
    input  logic [kem_ctrl_pkg::PC_W-1:0]    pc,
    output kem_ctrl_pkg::op_e                op,
    output logic                             src_bank,
    output logic                             dst_bank,
    output logic [ADDR_W-1:0]                src_base,
    output logic [ADDR_W-1:0]                dst_base,
    output logic [kem_ctrl_pkg::LEN_W-1:0]   len
);

    always_ff @(posedge clk) begin
        op       <= kem_ctrl_pkg::OP_END;   // unused slots end the program
        src_bank <= kem_ctrl_pkg::BANK_A;
        dst_bank <= kem_ctrl_pkg::BANK_B;
        src_base <= '0;
        dst_base <= '0;
        len      <= '0;
        case ({opermode, pc})
            {2'd0, 3'd0}: begin    // load 16 words
                op  <= kem_ctrl_pkg::OP_DIN;
                len <= 7'd16;
            end
            {2'd1, 3'd0}: begin    // hash 16 words a -> b
                op       <= kem_ctrl_pkg::OP_HASH;
                dst_base <= ADDR_W'(256);
                len      <= 7'd16;
            end
            {2'd2, 3'd0}: begin
                op       <= kem_ctrl_pkg::OP_DIN;
                src_base <= ADDR_W'(64);
                len      <= 7'd40;
            end
            {2'd2, 3'd1}: begin    // three absorb blocks at rate 17
                op       <= kem_ctrl_pkg::OP_HASH;
                src_base <= ADDR_W'(64);
                dst_base <= ADDR_W'(512);
                len      <= 7'd40;
            end
            {2'd2, 3'd2}: begin    // read back squeezed block
                op       <= kem_ctrl_pkg::OP_DOUT;
                src_bank <= kem_ctrl_pkg::BANK_B;
                dst_bank <= kem_ctrl_pkg::BANK_A;
                src_base <= ADDR_W'(512);
                len      <= 7'd17;
            end
            {2'd3, 3'd0}: begin
                op  <= kem_ctrl_pkg::OP_DOUT;
                len <= 7'd8;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: sequencer/op_sequencer.sv
// channel 0 is the source and channel 1 the destination; needs NUM_CHAN >= 2; start ignored while busy
`timescale 1ns/1ps
`default_nettype none

module op_sequencer #(
    parameter int ADDR_W   = 12,
    parameter int NUM_CHAN = 2
) (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  logic                                          start,
    input  logic                                          data_ival,
    input  logic                                          onehash_val,
    input  logic                                          sqzout_val,
    input  kem_ctrl_pkg::op_e                             op,
    input  logic                                          src_bank,
    input  logic                                          dst_bank,
    input  logic [ADDR_W-1:0]                             src_base,
    input  logic [ADDR_W-1:0]                             dst_base,
    input  logic [kem_ctrl_pkg::LEN_W-1:0]                len,
    input  logic                                          abs_done,
    input  logic                                          sqz_done,
    input  logic                                          words_left,
    input  logic [NUM_CHAN-1:0]                           ch_full,
    output logic [kem_ctrl_pkg::PC_W-1:0]                 pc,
    output logic [NUM_CHAN-1:0]                           ch_load,
    output logic [NUM_CHAN-1:0]                           ch_adv,
    output logic [NUM_CHAN-1:0]                           ch_write,
    output logic [NUM_CHAN-1:0]                           ch_bank,
    output logic [NUM_CHAN-1:0][ADDR_W-1:0]               ch_base,
    output logic [NUM_CHAN-1:0][kem_ctrl_pkg::LEN_W-1:0]  ch_len,
    output kem_ctrl_pkg::seq_state_e                      state,
    output logic                                          data_oval,
    output logic                                          work_done
);

    kem_ctrl_pkg::seq_state_e nxt_state;
    logic busy;
    logic fetching;    // rom output still stale after a pc change
    logic inst_vld;
    logic op_go;

    assign inst_vld = busy && !fetching;
    assign op_go    = (state == kem_ctrl_pkg::WAIT) && inst_vld && (op != kem_ctrl_pkg::OP_END);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc        <= '0;
            busy      <= 1'b0;
            fetching  <= 1'b0;
            work_done <= 1'b0;
            data_oval <= 1'b0;
        end else begin
            work_done <= 1'b0;
            fetching  <= 1'b0;
            data_oval <= (state == kem_ctrl_pkg::DOUT) && ch_adv[0];  // ram read latency
            if (start && !busy) begin
                pc       <= '0;
                busy     <= 1'b1;
                fetching <= 1'b1;
            end else if (state == kem_ctrl_pkg::WAIT && inst_vld &&
                         op == kem_ctrl_pkg::OP_END) begin
                busy      <= 1'b0;
                work_done <= 1'b1;
            end else if (state == kem_ctrl_pkg::DONE) begin
                pc       <= pc + 1'b1;
                fetching <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= kem_ctrl_pkg::WAIT;
        else
            state <= nxt_state;
    end

    always_comb begin
        nxt_state = state;
        case (state)
            kem_ctrl_pkg::WAIT: begin
                if (op_go) begin
                    case (op)
                        kem_ctrl_pkg::OP_DIN:  nxt_state = kem_ctrl_pkg::DIN;
                        kem_ctrl_pkg::OP_DOUT: nxt_state = kem_ctrl_pkg::DOUT;
                        default:               nxt_state = kem_ctrl_pkg::ABS;
                    endcase
                end
            end
            kem_ctrl_pkg::DIN,
            kem_ctrl_pkg::DOUT: if (ch_full[0]) nxt_state = kem_ctrl_pkg::DONE;
            kem_ctrl_pkg::ABS:  if (abs_done || ch_full[0]) nxt_state = kem_ctrl_pkg::RUN;
            kem_ctrl_pkg::RUN: begin
                if (onehash_val)
                    nxt_state = words_left ? kem_ctrl_pkg::ABS : kem_ctrl_pkg::SQZ;
            end
            kem_ctrl_pkg::SQZ:  if (sqz_done) nxt_state = kem_ctrl_pkg::DONE;
            default:            nxt_state = kem_ctrl_pkg::WAIT;   // DONE lasts one cycle
        endcase
    end

    // channel control, extra channels stay idle
    always_comb begin
        ch_load  = '0;
        ch_adv   = '0;
        ch_write = '0;
        ch_bank  = '0;
        ch_base  = '0;
        ch_len   = '0;
        ch_load[0] = op_go;
        ch_load[1] = op_go;
        ch_bank[0] = src_bank;
        ch_bank[1] = dst_bank;
        ch_base[0] = src_base;
        ch_base[1] = dst_base;
        ch_len[0]  = len;
        ch_len[1]  = '1;    // destination bounded by the squeeze count
        ch_write[0] = (state == kem_ctrl_pkg::DIN);
        ch_write[1] = (state == kem_ctrl_pkg::SQZ);
        case (state)
            kem_ctrl_pkg::DIN:  ch_adv[0] = data_ival && !ch_full[0];
            kem_ctrl_pkg::DOUT: ch_adv[0] = !ch_full[0];
            kem_ctrl_pkg::ABS:  ch_adv[0] = !abs_done && !ch_full[0];
            kem_ctrl_pkg::SQZ:  ch_adv[1] = sqzout_val && !sqz_done;
            default: ;
        endcase
    end

    a_no_adv_full: assert property (@(posedge clk) disable iff (!rstn)
        (ch_adv & ch_full) == '0);

    a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        work_done |=> !work_done);

endmodule

`default_nettype wire

// File: verif/tb_kem_ctrl.sv
// covers the four fixed rom programs only; sponge timing is random but seeded, stops at first error
`timescale 1ns/1ps
`default_nettype none

module tb_kem_ctrl;

    localparam int ADDR_W   = 12;
    localparam int NUM_ROWS = 5;
    localparam int TIMEOUT  = 3000;    // cycles per run

    typedef struct packed {
        logic [1:0]        mode;
        logic [1:0]        sec;
        logic [7:0]        n_msg;      // msg_val pulses
        logic [7:0]        n_perm;     // permutations requested
        logic [7:0]        n_wr_a;
        logic [7:0]        n_wr_b;
        logic [7:0]        n_oval;     // data_oval pulses
        logic [ADDR_W-1:0] wa_base;
        logic [ADDR_W-1:0] wb_base;
        logic              rd_bank;    // bank read by dout
        logic [ADDR_W-1:0] rd_base;
    } row_t;

    logic              clk = 1'b0;
    logic              rstn;
    logic [1:0]        sec_lvl;
    logic [1:0]        opermode;
    logic              start;
    logic              data_ival = 1'b0;
    logic              onehash_val = 1'b0;
    logic              sqzout_val = 1'b0;
    logic              work_done;
    logic              data_oval;
    logic              msg_val;
    logic              lastmsg_val;
    logic              sqzout_en;
    logic [ADDR_W-1:0] addr_64rama;
    logic [ADDR_W-1:0] addr_64ramb;
    logic              we_64rama;
    logic              we_64ramb;

    row_t              rows [NUM_ROWS];
    row_t              cur;
    int                rate;
    integer            seed = 32'h84ea;

    // counters owned by the monitor, cleared on start
    int                msg_cnt, last_cnt, blk_cnt, perm_cnt, hash_cnt;
    int                wa_cnt, wb_cnt, oval_cnt, done_cnt;
    int                exp_blk;
    logic [ADDR_W-1:0] prev_addr_a;
    logic [ADDR_W-1:0] prev_addr_b;

    // sponge model state
    int                hash_wait = 0;

    kem_ctrl_top #(.ADDR_W(ADDR_W), .NUM_CHAN(2)) dut (
        .clk(clk), .rstn(rstn), .sec_lvl(sec_lvl), .opermode(opermode), .start(start),
        .data_ival(data_ival), .onehash_val(onehash_val), .sqzout_val(sqzout_val),
        .work_done(work_done), .data_oval(data_oval), .msg_val(msg_val),
        .lastmsg_val(lastmsg_val), .sqzout_en(sqzout_en),
        .addr_64rama(addr_64rama), .addr_64ramb(addr_64ramb),
        .we_64rama(we_64rama), .we_64ramb(we_64ramb)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
    endtask

    task automatic check_idle();
        check("work_done", 32'(work_done), 0);
        check("data_oval", 32'(data_oval), 0);
        check("msg_val", 32'(msg_val), 0);
        check("lastmsg_val", 32'(lastmsg_val), 0);
        check("sqzout_en", 32'(sqzout_en), 0);
        check("we_64rama", 32'(we_64rama), 0);
        check("we_64ramb", 32'(we_64ramb), 0);
    endtask

    task automatic wait_done(input int row);
        int cyc;
        cyc = 0;
        while (done_cnt == 0) begin
            if (cyc == TIMEOUT) begin
                stop_run($sformatf("no work_done within %0d cycles in row %0d", TIMEOUT, row));
            end else begin
                @(negedge clk);
                cyc++;
            end
        end
    endtask

    // monitor, samples values held through the previous cycle
    always @(posedge clk) begin
        if (rstn && start) begin
            msg_cnt  = 0;
            last_cnt = 0;
            blk_cnt  = 0;
            perm_cnt = 0;
            hash_cnt = 0;
            wa_cnt   = 0;
            wb_cnt   = 0;
            oval_cnt = 0;
            done_cnt = 0;
        end else if (rstn) begin
            // no absorb or squeeze while a permutation is still running
            if ((msg_val || sqzout_en) && perm_cnt != hash_cnt)
                stop_run($sformatf("msg_val or sqzout_en at %0t while a permutation is pending",
                                   $time));
            if (msg_val) begin
                msg_cnt++;
                blk_cnt++;
            end
            if (lastmsg_val) begin
                last_cnt++;
                check("msg_val", 32'(msg_val), 1);    // last word must be a message word
                check("msg_val count at lastmsg_val", msg_cnt, 32'(cur.n_msg));
            end
            if (msg_val && (blk_cnt == rate || lastmsg_val)) begin   // block ends here
                exp_blk = cur.n_msg - (msg_cnt - blk_cnt);
                if (exp_blk > rate)
                    exp_blk = rate;
                check("absorb block length", blk_cnt, exp_blk);
                perm_cnt++;
                blk_cnt = 0;
            end
            if (we_64rama) begin
                check("addr_64rama", 32'(addr_64rama), cur.wa_base + wa_cnt);
                wa_cnt++;
            end
            if (we_64ramb) begin
                check("addr_64ramb", 32'(addr_64ramb), cur.wb_base + wb_cnt);
                wb_cnt++;
            end
            if (data_oval) begin
                // read address was presented one cycle earlier
                check(cur.rd_bank ? "addr_64ramb" : "addr_64rama",
                      32'(cur.rd_bank ? prev_addr_b : prev_addr_a), cur.rd_base + oval_cnt);
                oval_cnt++;
            end
            if (work_done)
                done_cnt++;
            if (onehash_val)
                hash_cnt++;
        end
        prev_addr_a = addr_64rama;
        prev_addr_b = addr_64ramb;
    end

    // sponge model and input data source
    always @(negedge clk) begin
        if (!rstn) begin
            data_ival   <= 1'b0;
            onehash_val <= 1'b0;
            sqzout_val  <= 1'b0;
        end else begin
            data_ival   <= ($random(seed) & 1) != 0;
            sqzout_val  <= sqzout_en && (($random(seed) & 3) != 0);
            onehash_val <= 1'b0;
            if (perm_cnt != hash_cnt) begin
                if (hash_wait == 0)
                    hash_wait = 1 + ($random(seed) & 3);   // permutation length
                hash_wait = hash_wait - 1;
                if (hash_wait == 0)
                    onehash_val <= 1'b1;
            end
        end
    end

    initial begin
        rstn     = 1'b0;
        sec_lvl  = 2'b00;
        opermode = 2'd0;
        start    = 1'b0;
        // mode, sec_lvl, msg, perm, wr a, wr b, oval, wr a base, wr b base, rd bank, rd base
        rows[0] = {2'd0, 2'b00, 8'd0, 8'd0, 8'd16, 8'd0, 8'd0, 12'd0, 12'd0, 1'b0, 12'd0};
        rows[1] = {2'd1, 2'b01, 8'd16, 8'd1, 8'd0, 8'd21, 8'd0, 12'd0, 12'd256, 1'b0, 12'd0};
        rows[2] = {2'd2, 2'b00, 8'd40, 8'd3, 8'd40, 8'd17, 8'd17, 12'd64, 12'd512, 1'b1,
                   12'd512};
        rows[3] = {2'd3, 2'b00, 8'd0, 8'd0, 8'd0, 8'd0, 8'd8, 12'd0, 12'd0, 1'b0, 12'd0};
        rows[4] = {2'd1, 2'b10, 8'd16, 8'd1, 8'd0, 8'd17, 8'd0, 12'd0, 12'd256, 1'b0, 12'd0};
        cur  = rows[0];
        rate = 17;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check_idle();

        for (int r = 0; r < NUM_ROWS; r++) begin
            cur      = rows[r];
            rate     = cur.sec[0] ? 21 : 17;    // only bit 0 picks the rate
            opermode <= cur.mode;
            sec_lvl  <= cur.sec;
            start    <= 1'b1;
            @(negedge clk);
            start <= 1'b0;
            wait_done(r);
            repeat (4) begin    // quiet window between runs
                check_idle();
                @(negedge clk);
            end
            check("work_done pulses", done_cnt, 1);
            check("msg_val pulses", msg_cnt, 32'(cur.n_msg));
            check("lastmsg_val pulses", last_cnt, (cur.n_msg != 0) ? 1 : 0);
            check("onehash_val requests", perm_cnt, 32'(cur.n_perm));
            check("we_64rama pulses", wa_cnt, 32'(cur.n_wr_a));
            check("we_64ramb pulses", wb_cnt, 32'(cur.n_wr_b));
            check("data_oval pulses", oval_cnt, 32'(cur.n_oval));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
